// ==== Bender.yml ====
package:
  name: disk_bridge

sources:
  - files:
      - hw/disk_bridge_pkg.sv
      - hw/sector_buffer.sv
      - hw/buffer_pointer.sv
      - hw/block_request_fsm.sv
      - hw/mount_tracker.sv
      - hw/apb_disk_regs.sv
      - hw/disk_bridge_top.sv
  - target: test
    files:
      - testbench/disk_bridge_tb.sv

// ==== hw/apb_disk_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_disk_regs
	import disk_bridge_pkg::*;
(
	input  logic       clk_sys,
	input  logic       areset,
	// APB slave
	input  logic       psel_i,
	input  logic       penable_i,
	input  logic       pwrite_i,
	input  apb_addr_t  paddr_i,
	input  apb_data_t  pwdata_i,
	output apb_data_t  prdata_o,
	output logic       pready_o,
	output logic       pslverr_o,
	// Status sources
	input  byte_t      buf_rdata_i,
	input  logic       io_done_i,
	input  logic       mount_toggle_i,
	input  drive_num_t mount_drive_i,
	input  file_type_t file_type_i,
	input  logic       readonly_i,
	input  file_size_t file_size_i,
	// Control outputs
	output logic       lba_sel_o,
	output logic       block_rd_o,
	output logic       block_wr_o,
	output drive_num_t drive_o,
	output lba_t       lba_o,
	output logic       buf_we_o,
	output byte_t      buf_wdata_o,
	output logic       ptr_incr_o,
	output logic       ptr_clear_o
);

	logic access;
	logic sel_ctrl;
	logic sel_status;
	logic sel_data;
	logic sel_addr_clr;
	logic mapped;
	logic data_rd;
	logic data_wait_q;
	logic wr_done;

	// ==============================
	// Decode and handshake
	// ==============================
	assign access       = psel_i & penable_i;
	assign sel_ctrl     = (paddr_i == REG_CTRL);
	assign sel_status   = (paddr_i == REG_STATUS);
	assign sel_data     = (paddr_i == REG_DATA);
	assign sel_addr_clr = (paddr_i == REG_ADDR_CLR);
	assign mapped       = sel_ctrl | sel_status | sel_data | sel_addr_clr;
	assign data_rd      = access & sel_data & ~pwrite_i;

	// DATA reads stall one cycle for the registered buffer output
	assign pready_o  = access & ~(data_rd & ~data_wait_q);
	assign pslverr_o = pready_o & ~mapped;
	assign wr_done   = pready_o & pwrite_i & mapped;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			data_wait_q <= 1'b0;
		end else if (pready_o) begin
			data_wait_q <= 1'b0;
		end else if (data_rd) begin
			data_wait_q <= 1'b1;
		end
	end

	// ==============================
	// CTRL and LBA registers
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			lba_sel_o  <= 1'b0;
			block_rd_o <= 1'b0;
			block_wr_o <= 1'b0;
			drive_o    <= '0;
			lba_o      <= '0;
		end else if (wr_done) begin
			if (sel_ctrl) begin
				lba_sel_o  <= pwdata_i[CTRL_LBA_SEL_BIT];
				block_rd_o <= pwdata_i[CTRL_BLOCK_RD_BIT];
				block_wr_o <= pwdata_i[CTRL_BLOCK_WR_BIT];
				drive_o    <= pwdata_i[CTRL_DRIVE_LSB +: $bits(drive_num_t)];
			end
			if (sel_data && lba_sel_o) begin
				lba_o <= pwdata_i;
			end
		end
	end

	// Buffer and pointer strobes, only when lba_sel is clear
	assign buf_we_o    = wr_done & sel_data & ~lba_sel_o;
	assign buf_wdata_o = pwdata_i[7:0];
	assign ptr_incr_o  = pready_o & sel_data & ~lba_sel_o;
	assign ptr_clear_o = wr_done & sel_addr_clr;

	// ==============================
	// Read data
	// ==============================
	always_comb begin
		prdata_o = '0;
		if (sel_ctrl) begin
			prdata_o[CTRL_LBA_SEL_BIT]                         = lba_sel_o;
			prdata_o[CTRL_BLOCK_RD_BIT]                        = block_rd_o;
			prdata_o[CTRL_BLOCK_WR_BIT]                        = block_wr_o;
			prdata_o[CTRL_DRIVE_LSB +: $bits(drive_num_t)]     = drive_o;
		end else if (sel_status) begin
			prdata_o[7:0] = {readonly_i, file_type_i, mount_drive_i, mount_toggle_i, io_done_i};
		end else if (sel_data) begin
			// File size takes the place of the buffer byte while lba_sel is set
			prdata_o = lba_sel_o ? apb_data_t'(file_size_i) : apb_data_t'(buf_rdata_i);
		end
	end

endmodule

`default_nettype wire

// ==== hw/block_request_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_request_fsm
	import disk_bridge_pkg::*;
(
	input  logic        clk_sys,
	input  logic        areset,
	input  logic        block_rd_i,
	input  logic        block_wr_i,
	input  drive_num_t  drive_i,
	input  drive_mask_t sd_ack_i,
	output drive_mask_t sd_rd_o,
	output drive_mask_t sd_wr_o,
	output logic        io_done_o
);

	req_state_t  state_q;
	logic        rd_prev_q;
	logic        wr_prev_q;
	logic        rd_edge;
	logic        wr_edge;
	logic        any_ack;
	drive_num_t  drive_q;
	logic        is_wr_q;
	logic        io_done_q;
	drive_mask_t drive_onehot;

	assign rd_edge = block_rd_i & ~rd_prev_q;
	assign wr_edge = block_wr_i & ~wr_prev_q;
	assign any_ack = |sd_ack_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			state_q   <= REQ_IDLE;
			rd_prev_q <= 1'b0;
			wr_prev_q <= 1'b0;
			drive_q   <= '0;
			is_wr_q   <= 1'b0;
			io_done_q <= 1'b1;
		end else begin
			rd_prev_q <= block_rd_i;
			wr_prev_q <= block_wr_i;
			case (state_q)
				REQ_IDLE: begin
					// Read takes precedence when both bits rise together
					if (rd_edge || wr_edge) begin
						drive_q   <= drive_i;
						is_wr_q   <= ~rd_edge;
						io_done_q <= 1'b0;
						state_q   <= REQ_WAIT_ACK;
					end
				end
				REQ_WAIT_ACK: begin
					// Host picked the request up, so drop it
					if (any_ack) begin
						state_q <= REQ_WAIT_END;
					end
				end
				REQ_WAIT_END: begin
					if (!any_ack) begin
						io_done_q <= 1'b1;
						state_q   <= REQ_IDLE;
					end
				end
				default: state_q <= REQ_IDLE;
			endcase
		end
	end

	// Request line of the latched drive only, while waiting for the host
	assign drive_onehot = drive_mask_t'(1) << drive_q;
	assign sd_rd_o      = (state_q == REQ_WAIT_ACK && !is_wr_q) ? drive_onehot : '0;
	assign sd_wr_o      = (state_q == REQ_WAIT_ACK &&  is_wr_q) ? drive_onehot : '0;
	assign io_done_o    = io_done_q;

endmodule

`default_nettype wire

// ==== hw/buffer_pointer.sv ====
`timescale 1ns/1ps
`default_nettype none

module buffer_pointer
	import disk_bridge_pkg::*;
(
	input  logic      clk_sys,
	input  logic      areset,
	input  logic      clear_i,
	input  logic      incr_i,
	output buf_addr_t addr_o
);

	buf_addr_t addr_q;

	// Clear wins over increment
	// Rolls over from 511 back to 0 by width
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			addr_q <= '0;
		end else if (clear_i) begin
			addr_q <= '0;
		end else if (incr_i) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign addr_o = addr_q;

endmodule

`default_nettype wire

// ==== hw/disk_bridge_pkg.sv ====
`default_nettype none

package disk_bridge_pkg;

	// ==============================
	// Sizes
	// ==============================
	localparam int NUM_DRIVES = 8;
	localparam int BUF_AW     = 9;
	localparam int APB_AW     = 4;

	// ==============================
	// Register map
	// ==============================
	// Byte offsets, one 32-bit word each
	localparam logic [APB_AW-1:0] REG_CTRL     = 4'h0;
	localparam logic [APB_AW-1:0] REG_STATUS   = 4'h4;
	localparam logic [APB_AW-1:0] REG_DATA     = 4'h8;
	localparam logic [APB_AW-1:0] REG_ADDR_CLR = 4'hC;

	// CTRL fields
	localparam int CTRL_LBA_SEL_BIT  = 0;
	localparam int CTRL_BLOCK_RD_BIT = 1;
	localparam int CTRL_BLOCK_WR_BIT = 2;
	localparam int CTRL_DRIVE_LSB    = 3;

	// Slots that always mount read-only
	localparam int RO_DRIVE_A = 4;
	localparam int RO_DRIVE_B = 5;

	// ==============================
	// Types
	// ==============================
	typedef logic [7:0]                      byte_t;
	typedef logic [BUF_AW-1:0]               buf_addr_t;
	typedef logic [NUM_DRIVES-1:0]           drive_mask_t;
	typedef logic [$clog2(NUM_DRIVES)-1:0]   drive_num_t;
	typedef logic [1:0]                      file_type_t;
	typedef logic [31:0]                     lba_t;
	typedef logic [31:0]                     file_size_t;
	typedef logic [APB_AW-1:0]               apb_addr_t;
	typedef logic [31:0]                     apb_data_t;

	// Block request sequencing
	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_WAIT_ACK,
		REQ_WAIT_END
	} req_state_t;

endpackage

`default_nettype wire

// ==== hw/disk_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module disk_bridge_top
	import disk_bridge_pkg::*;
(
	input  logic        clk_sys,
	input  logic        areset,
	// APB slave
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  apb_addr_t   paddr_i,
	input  apb_data_t   pwdata_i,
	output apb_data_t   prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,
	// Host block requests
	output drive_mask_t sd_rd_o,
	output drive_mask_t sd_wr_o,
	input  drive_mask_t sd_ack_i,
	output lba_t        sd_lba_o,
	// Host buffer access
	input  buf_addr_t   sd_buff_addr_i,
	input  byte_t       sd_buff_dout_i,
	input  logic        sd_buff_wr_i,
	output byte_t       sd_buff_din_o,
	// Image mount events
	input  drive_mask_t img_mounted_i,
	input  logic        img_readonly_i,
	input  file_size_t  img_size_i,
	input  file_type_t  img_type_i
);

	logic       block_rd;
	logic       block_wr;
	drive_num_t ctrl_drive;
	logic       buf_we;
	byte_t      buf_wdata;
	byte_t      buf_rdata;
	logic       ptr_incr;
	logic       ptr_clear;
	buf_addr_t  ptr_addr;
	logic       io_done;
	logic       mount_toggle;
	drive_num_t mount_drive;
	file_type_t file_type;
	logic       readonly;
	file_size_t file_size;

	// ==============================
	// Firmware register block
	// ==============================
	apb_disk_regs u_regs (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.psel_i         (psel_i),
		.penable_i      (penable_i),
		.pwrite_i       (pwrite_i),
		.paddr_i        (paddr_i),
		.pwdata_i       (pwdata_i),
		.prdata_o       (prdata_o),
		.pready_o       (pready_o),
		.pslverr_o      (pslverr_o),
		.buf_rdata_i    (buf_rdata),
		.io_done_i      (io_done),
		.mount_toggle_i (mount_toggle),
		.mount_drive_i  (mount_drive),
		.file_type_i    (file_type),
		.readonly_i     (readonly),
		.file_size_i    (file_size),
		// lba_sel only steers the DATA register inside the block
		.lba_sel_o      (),
		.block_rd_o     (block_rd),
		.block_wr_o     (block_wr),
		.drive_o        (ctrl_drive),
		.lba_o          (sd_lba_o),
		.buf_we_o       (buf_we),
		.buf_wdata_o    (buf_wdata),
		.ptr_incr_o     (ptr_incr),
		.ptr_clear_o    (ptr_clear)
	);

	buffer_pointer u_ptr (
		.clk_sys (clk_sys),
		.areset  (areset),
		.clear_i (ptr_clear),
		.incr_i  (ptr_incr),
		.addr_o  (ptr_addr)
	);

	// Port A for firmware, port B for host
	sector_buffer u_buf (
		.clk_sys   (clk_sys),
		.a_addr_i  (ptr_addr),
		.a_wdata_i (buf_wdata),
		.a_we_i    (buf_we),
		.a_rdata_o (buf_rdata),
		.b_addr_i  (sd_buff_addr_i),
		.b_wdata_i (sd_buff_dout_i),
		.b_we_i    (sd_buff_wr_i),
		.b_rdata_o (sd_buff_din_o)
	);

	// ==============================
	// Host side control
	// ==============================
	block_request_fsm u_req (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.block_rd_i (block_rd),
		.block_wr_i (block_wr),
		.drive_i    (ctrl_drive),
		.sd_ack_i   (sd_ack_i),
		.sd_rd_o    (sd_rd_o),
		.sd_wr_o    (sd_wr_o),
		.io_done_o  (io_done)
	);

	mount_tracker u_mount (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.mount_toggle_o (mount_toggle),
		.drive_o        (mount_drive),
		.file_type_o    (file_type),
		.readonly_o     (readonly),
		.file_size_o    (file_size)
	);

endmodule

`default_nettype wire

// ==== hw/mount_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mount_tracker
	import disk_bridge_pkg::*;
(
	input  logic        clk_sys,
	input  logic        areset,
	input  drive_mask_t img_mounted_i,
	input  logic        img_readonly_i,
	input  file_size_t  img_size_i,
	input  file_type_t  img_type_i,
	output logic        mount_toggle_o,
	output drive_num_t  drive_o,
	output file_type_t  file_type_o,
	output logic        readonly_o,
	output file_size_t  file_size_o
);

	logic       any_prev_q;
	logic       mount_edge;
	drive_num_t top_drive;

	assign mount_edge = (|img_mounted_i) & ~any_prev_q;

	// Highest set bit decides the drive number
	always_comb begin
		top_drive = '0;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (img_mounted_i[i]) begin
				top_drive = drive_num_t'(i);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			any_prev_q     <= 1'b0;
			mount_toggle_o <= 1'b0;
		end else begin
			any_prev_q <= |img_mounted_i;
			if (mount_edge) begin
				mount_toggle_o <= ~mount_toggle_o;
			end
		end
	end

	// Mount details, refreshed on every mount event
	always_ff @(posedge clk_sys) begin
		if (mount_edge) begin
			drive_o     <= top_drive;
			file_type_o <= img_type_i;
			file_size_o <= img_size_i;
			readonly_o  <= img_readonly_i
				| (top_drive == drive_num_t'(RO_DRIVE_A))
				| (top_drive == drive_num_t'(RO_DRIVE_B));
		end
	end

endmodule

`default_nettype wire

// ==== hw/sector_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sector_buffer
	import disk_bridge_pkg::*;
(
	input  logic      clk_sys,
	// Port A serves the firmware
	input  buf_addr_t a_addr_i,
	input  byte_t     a_wdata_i,
	input  logic      a_we_i,
	output byte_t     a_rdata_o,
	// Port B serves the host
	input  buf_addr_t b_addr_i,
	input  byte_t     b_wdata_i,
	input  logic      b_we_i,
	output byte_t     b_rdata_o
);

	// One full sector
	byte_t mem [2**BUF_AW];

	// Write-first on both ports
	always @(posedge clk_sys) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
			a_rdata_o     <= a_wdata_i;
		end else begin
			a_rdata_o <= mem[a_addr_i];
		end
	end

	always @(posedge clk_sys) begin
		if (b_we_i) begin
			mem[b_addr_i] <= b_wdata_i;
			b_rdata_o     <= b_wdata_i;
		end else begin
			b_rdata_o <= mem[b_addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== testbench/disk_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module disk_bridge_tb
	import disk_bridge_pkg::*;
();

	localparam int          CLK_NS     = 4;
	localparam logic [31:0] SEED       = 32'h912a_7a05;
	localparam int          BUF_BYTES  = 2**BUF_AW;
	localparam int          NUM_REQS   = 12;
	localparam int          NUM_MOUNTS = 24;

	// Transfer count of each test, 50 watchdog cycles per transfer
	localparam int XFER_RESET = 6;
	localparam int XFER_FW    = 2 + 2 * BUF_BYTES;
	localparam int XFER_HOST  = 3 + 2 * BUF_BYTES;
	localparam int XFER_BLOCK = NUM_REQS * 12;
	localparam int XFER_MOUNT = NUM_MOUNTS * 5;
	localparam int XFER_ERR   = 32;
	localparam int XFER_TOTAL = XFER_RESET + XFER_FW + XFER_HOST + XFER_BLOCK
		+ XFER_MOUNT + XFER_ERR;

	logic        clk_sys;
	logic        areset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata;
	apb_data_t   prdata;
	logic        pready;
	logic        pslverr;
	drive_mask_t sd_rd;
	drive_mask_t sd_wr;
	drive_mask_t sd_ack;
	lba_t        sd_lba;
	buf_addr_t   sd_buff_addr;
	byte_t       sd_buff_dout;
	logic        sd_buff_wr;
	byte_t       sd_buff_din;
	drive_mask_t img_mounted;
	logic        img_readonly;
	file_size_t  img_size;
	file_type_t  img_type;

	// Reference data and mount model
	byte_t       fw_bytes [BUF_BYTES];
	byte_t       host_bytes [BUF_BYTES];
	logic        model_toggle;
	drive_num_t  model_drive;
	file_type_t  model_type;
	logic        model_ro;
	file_size_t  model_size;
	req_state_t  fsm_state;

	assign fsm_state = dut0.u_req.state_q;

	disk_bridge_top dut0 (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.psel_i         (psel),
		.penable_i      (penable),
		.pwrite_i       (pwrite),
		.paddr_i        (paddr),
		.pwdata_i       (pwdata),
		.prdata_o       (prdata),
		.pready_o       (pready),
		.pslverr_o      (pslverr),
		.sd_rd_o        (sd_rd),
		.sd_wr_o        (sd_wr),
		.sd_ack_i       (sd_ack),
		.sd_lba_o       (sd_lba),
		.sd_buff_addr_i (sd_buff_addr),
		.sd_buff_dout_i (sd_buff_dout),
		.sd_buff_wr_i   (sd_buff_wr),
		.sd_buff_din_o  (sd_buff_din),
		.img_mounted_i  (img_mounted),
		.img_readonly_i (img_readonly),
		.img_size_i     (img_size),
		.img_type_i     (img_type)
	);

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	// ==============================
	// Reference model
	// ==============================
	function automatic apb_data_t expected_status(input logic io_done);
		apb_data_t s;
		s      = '0;
		s[0]   = io_done;
		s[1]   = model_toggle;
		s[4:2] = model_drive;
		s[6:5] = model_type;
		s[7]   = model_ro;
		return s;
	endfunction

	// Scans from the top slot down
	function automatic drive_num_t highest_drive(input drive_mask_t mask);
		for (int i = NUM_DRIVES - 1; i >= 0; i--) begin
			if (mask[i]) begin
				return drive_num_t'(i);
			end
		end
		return '0;
	endfunction

	function automatic apb_data_t ctrl_word(input logic lba_sel, input logic rd,
		input logic wr, input drive_num_t drive);
		apb_data_t w;
		w                          = '0;
		w[CTRL_LBA_SEL_BIT]        = lba_sel;
		w[CTRL_BLOCK_RD_BIT]       = rd;
		w[CTRL_BLOCK_WR_BIT]       = wr;
		w[CTRL_DRIVE_LSB +: 3]     = drive;
		return w;
	endfunction

	// ==============================
	// Checks and APB master
	// ==============================
	task automatic fail_and_stop();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
			fail_and_stop();
		end
	endtask

	task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err, output int waits);
		logic done;
		done  = 1'b0;
		waits = 0;
		@(negedge clk_sys);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk_sys);
		penable = 1'b1;
		while (!done) begin
			@(posedge clk_sys);
			if (pready) begin
				done  = 1'b1;
				rdata = prdata;
				err   = pslverr;
			end else begin
				waits++;
			end
		end
		@(negedge clk_sys);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rdata;
		logic      err;
		int        waits;
		apb_xfer(1'b1, addr, data, rdata, err, waits);
		check("slave error on write", 0, err);
		check("wait states on write", 0, waits);
	endtask

	// Only DATA reads take one wait state
	task automatic reg_read(input string name, input apb_addr_t addr, output apb_data_t data);
		logic err;
		int   waits;
		apb_xfer(1'b0, addr, '0, data, err, waits);
		check({name, " slave error"}, 0, err);
		check({name, " wait states"}, (addr == REG_DATA) ? 1 : 0, waits);
	endtask

	// ==============================
	// Host side
	// ==============================
	task automatic host_write_buffer();
		for (int i = 0; i < BUF_BYTES; i++) begin
			@(negedge clk_sys);
			host_bytes[i] = byte_t'($urandom);
			sd_buff_addr  = buf_addr_t'(i);
			sd_buff_dout  = host_bytes[i];
			sd_buff_wr    = 1'b1;
		end
		@(negedge clk_sys);
		sd_buff_wr = 1'b0;
	endtask

	// Data of address i shows up at the edge after it is driven
	task automatic host_read_buffer();
		for (int i = 0; i <= BUF_BYTES; i++) begin
			@(negedge clk_sys);
			if (i < BUF_BYTES) begin
				sd_buff_addr = buf_addr_t'(i);
			end
			@(posedge clk_sys);
			if (i > 0) begin
				check("host read back", fw_bytes[i-1], sd_buff_din);
			end
		end
	endtask

	// Request must stay up through the random delay before the ack
	task automatic host_ack_begin(input drive_num_t drive, input drive_mask_t exp_req);
		int delay;
		delay = 1 + ($urandom % 20);
		repeat (delay) begin
			@(posedge clk_sys);
			check("request held until ack", exp_req, sd_rd | sd_wr);
		end
		@(negedge clk_sys);
		sd_ack[drive] = 1'b1;
	endtask

	task automatic host_ack_end();
		repeat ($urandom % 8) @(negedge clk_sys);
		@(negedge clk_sys);
		sd_ack = '0;
	endtask

	task automatic run_block_request(input logic rd_bit, input logic wr_bit,
		input drive_num_t drive);
		drive_mask_t exp_rd;
		drive_mask_t exp_wr;
		apb_data_t   rdata;
		lba_t        lba;
		logic        seen;
		int          latency;
		// Read wins when both bits rise together
		exp_rd = rd_bit ? drive_mask_t'(1) << drive : '0;
		exp_wr = rd_bit ? '0 : drive_mask_t'(1) << drive;
		lba    = $urandom;
		reg_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, drive));
		reg_write(REG_DATA, lba);
		check("sd_lba_o", lba, sd_lba);
		reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, drive));
		reg_write(REG_CTRL, ctrl_word(1'b0, rd_bit, wr_bit, drive));
		latency = 0;
		seen    = 1'b0;
		while (!seen) begin
			@(posedge clk_sys);
			latency++;
			seen = ((sd_rd | sd_wr) != '0);
			if (!seen && latency > 8) begin
				$display("request for drive %0d never raised, FSM in %s",
					drive, fsm_state.name());
				fail_and_stop();
			end
		end
		check("request latency", 2, latency);
		check("sd_rd_o request", exp_rd, sd_rd);
		check("sd_wr_o request", exp_wr, sd_wr);
		reg_read("io_done while busy", REG_STATUS, rdata);
		check("io_done while busy", 0, rdata[0]);
		// Fresh edges on another drive while busy
		reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, drive + 1'b1));
		reg_write(REG_CTRL, ctrl_word(1'b0, 1'b1, 1'b1, drive + 1'b1));
		host_ack_begin(drive, exp_rd | exp_wr);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("request drops after ack", 0, sd_rd | sd_wr);
		reg_read("io_done during ack", REG_STATUS, rdata);
		check("io_done during ack", 0, rdata[0]);
		host_ack_end();
		reg_read("io_done after ack", REG_STATUS, rdata);
		check("io_done after ack", 1, rdata[0]);
		repeat (3) @(posedge clk_sys);
		check("no second request", 0, sd_rd | sd_wr);
	endtask

	task automatic run_mount(input drive_mask_t mask);
		apb_data_t  rdata;
		file_size_t size;
		file_type_t ftype;
		logic       ro;
		size  = $urandom;
		ftype = file_type_t'($urandom);
		ro    = 1'($urandom);
		@(negedge clk_sys);
		img_mounted  = mask;
		img_type     = ftype;
		img_readonly = ro;
		img_size     = size;
		@(negedge clk_sys);
		img_mounted  = '0;
		model_toggle = ~model_toggle;
		model_drive  = highest_drive(mask);
		model_type   = ftype;
		model_ro     = ro || model_drive == RO_DRIVE_A || model_drive == RO_DRIVE_B;
		model_size   = size;
		reg_read("mount status", REG_STATUS, rdata);
		check("mount status", expected_status(1'b1), rdata);
		reg_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, '0));
		reg_read("file size", REG_DATA, rdata);
		check("file size", model_size, rdata);
		reg_write(REG_CTRL, '0);
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		apb_data_t   rdata;
		logic        err;
		int          waits;
		logic [31:0] seed_ret;
		drive_mask_t mask;
		clk_sys      = 1'b0;
		areset       = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		sd_ack       = '0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		img_size     = '0;
		img_type     = '0;
		model_toggle = 1'b0;
		model_drive  = '0;
		model_type   = '0;
		model_ro     = 1'b0;
		model_size   = '0;
		seed_ret     = $urandom(SEED);
		repeat (10) @(negedge clk_sys);
		areset = 1'b0;

		$display("test: reset state");
		@(posedge clk_sys);
		check("sd_rd_o after reset", 0, sd_rd);
		check("sd_wr_o after reset", 0, sd_wr);
		check("pready_o after reset", 0, pready);
		check("pslverr_o after reset", 0, pslverr);
		check("sd_lba_o after reset", 0, sd_lba);
		reg_read("reset status", REG_STATUS, rdata);
		// Mount fields in bits 7:2 hold no value before the first mount
		check("reset status", expected_status(1'b1) & 32'hffff_ff03,
			rdata & 32'hffff_ff03);
		reg_read("reset ctrl", REG_CTRL, rdata);
		check("reset ctrl", 0, rdata);

		$display("test: firmware to host");
		reg_write(REG_CTRL, '0);
		reg_write(REG_ADDR_CLR, '0);
		for (int i = 0; i < BUF_BYTES; i++) begin
			fw_bytes[i] = byte_t'($urandom);
			reg_write(REG_DATA, {24'($urandom), fw_bytes[i]});
		end
		host_read_buffer();

		$display("test: host to firmware");
		host_write_buffer();
		reg_write(REG_ADDR_CLR, '0);
		for (int i = 0; i < BUF_BYTES; i++) begin
			reg_read("host to firmware", REG_DATA, rdata);
			check("host to firmware", host_bytes[i], rdata);
		end
		reg_read("pointer wrap", REG_DATA, rdata);
		check("pointer wrap", host_bytes[0], rdata);

		$display("test: block requests");
		for (int i = 0; i < NUM_REQS; i++) begin
			run_block_request(i % 3 != 1, i % 3 != 0, drive_num_t'($urandom));
		end

		$display("test: mount tracking");
		for (int i = 0; i < NUM_MOUNTS; i++) begin
			if (i % 2 == 0) begin
				mask = drive_mask_t'(1) << ($urandom % NUM_DRIVES);
			end else begin
				mask = drive_mask_t'($urandom) | drive_mask_t'(1);
			end
			run_mount(mask);
		end

		$display("test: unmapped addresses");
		reg_write(REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 3'd3));
		reg_write(REG_ADDR_CLR, '0);
		for (int i = 0; i < 3; i++) begin
			reg_read("data before error", REG_DATA, rdata);
			check("data before error", host_bytes[i], rdata);
		end
		for (int a = 0; a < 16; a++) begin
			if (a % 4 != 0) begin
				apb_xfer(1'b1, apb_addr_t'(a), 32'hffff_ffff, rdata, err, waits);
				check("unmapped write pslverr", 1, err);
				check("unmapped write wait states", 0, waits);
				apb_xfer(1'b0, apb_addr_t'(a), '0, rdata, err, waits);
				check("unmapped read pslverr", 1, err);
				check("unmapped read wait states", 0, waits);
			end
		end
		reg_read("ctrl after error", REG_CTRL, rdata);
		check("ctrl after error", ctrl_word(1'b0, 1'b0, 1'b0, 3'd3), rdata);
		reg_read("pointer after error", REG_DATA, rdata);
		check("pointer after error", host_bytes[3], rdata);

		$display("Simulation passed");
		$finish;
	end

	// Watchdog
	initial begin
		#(XFER_TOTAL * 50 * CLK_NS);
		$display("timeout: tests did not finish within %0d cycles", XFER_TOTAL * 50);
		fail_and_stop();
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/disk_bridge_pkg.sv
hw/sector_buffer.sv
hw/buffer_pointer.sv
hw/block_request_fsm.sv
hw/mount_tracker.sv
hw/apb_disk_regs.sv
hw/disk_bridge_top.sv
testbench/disk_bridge_tb.sv
